//--- rv_dec_pkg.sv
// RV32I decode stage shared definitions
// Widths, major opcodes, ALU and LSU codes, sequencer states
// and the format views of an instruction word
package rv_dec_pkg;

  localparam int DATA_WIDTH     = 32;
  localparam int REG_ADDR_WIDTH = 5;
  localparam int ALU_OP_WIDTH   = 4;
  localparam int LSU_CTRL_WIDTH = 4;  // Store bit over funct3

  //////////////////////////////////////////////////
  // Major opcodes and function codes
  //////////////////////////////////////////////////
  localparam logic [6:0] OPCODE_OP    = 7'b0110011;
  localparam logic [6:0] OPCODE_OPIMM = 7'b0010011;
  localparam logic [6:0] OPCODE_LUI   = 7'b0110111;
  localparam logic [6:0] OPCODE_AUIPC = 7'b0010111;
  localparam logic [6:0] OPCODE_LOAD  = 7'b0000011;
  localparam logic [6:0] OPCODE_STORE = 7'b0100011;

  localparam logic [2:0] FUNCT3_SHIFT_L = 3'b001;
  localparam logic [2:0] FUNCT3_SHIFT_R = 3'b101;  // SRL and SRA, split by bit 30

  localparam logic [ALU_OP_WIDTH-1:0] ALU_OP_ADD = 4'b0000;

  //////////////////////////////////////////////////
  // Instruction word views
  //////////////////////////////////////////////////
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic [19:0] imm20;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    u_fmt_t u_fmt;
  } instr_u;

  // One-hot sequencer states
  typedef enum logic [7:0] {
    S_READY     = 8'b0000_0001,
    S_STALL     = 8'b0000_0010,
    S_ST_ADDR   = 8'b0000_0100,
    S_ST_ISSUE  = 8'b0000_1000,
    S_LD_ADDR   = 8'b0001_0000,
    S_LD_ISSUE  = 8'b0010_0000,
    S_LD_WAIT   = 8'b0100_0000,
    S_NOT_VALID = 8'b1000_0000
  } seq_state_e;

  typedef enum logic [2:0] {
    IMM_NONE        = 3'd0,
    IMM_I           = 3'd1,
    IMM_SHAMT       = 3'd2,
    IMM_S           = 3'd3,
    IMM_U           = 3'd4,
    IMM_FOUR_UNUSED = 3'd5   // Reserved
  } imm_sel_e;

endpackage

//--- imm_gen.sv
// Immediate generator
// Builds the extended immediate of the selected instruction format
`timescale 1ns/1ps

module imm_gen
  import rv_dec_pkg::*;
(
  input  instr_u                instr_i,
  input  imm_sel_e              imm_sel_i,
  output logic [DATA_WIDTH-1:0] imm_o
);

  logic [11:0] s_imm;

  assign s_imm = {instr_i.s_fmt.imm_hi, instr_i.s_fmt.imm_lo};

  always_comb begin
    case (imm_sel_i)
      IMM_I:     imm_o = {{(DATA_WIDTH-12){instr_i.i_fmt.imm12[11]}}, instr_i.i_fmt.imm12};
      IMM_SHAMT: imm_o = {{(DATA_WIDTH-5){1'b0}}, instr_i.i_fmt.imm12[4:0]};  // Unsigned
      IMM_S:     imm_o = {{(DATA_WIDTH-12){s_imm[11]}}, s_imm};
      IMM_U:     imm_o = {instr_i.u_fmt.imm20, 12'b0};
      default:   imm_o = '0;
    endcase
  end

  // The reserved selector belongs to no supported format
  always_comb begin
    a_no_reserved_sel: assert (imm_sel_i !== IMM_FOUR_UNUSED)
      else $error("imm_gen: reserved immediate selector used");
  end

endmodule

//--- hazard_check.sv
// Read-after-write hazard check
// Keeps the destination of the last accepted instruction and flags
// a source register that matches it
`timescale 1ns/1ps

module hazard_check
  import rv_dec_pkg::*;
(
  input  logic       clk_i,
  input  logic       rstn_i,
  input  instr_u     instr_i,
  input  logic       accept_i,
  input  seq_state_e state_i,
  output logic       raw_hazard_o
);

  logic [REG_ADDR_WIDTH-1:0] last_rd_q;
  logic                      fresh_q;  // Set while in the first cycle of a new instruction
  logic                      use_rs1;
  logic                      use_rs2;
  logic                      writes_rd;
  logic                      rs1_hit;
  logic                      rs2_hit;

  always_comb begin
    use_rs1   = 1'b0;
    use_rs2   = 1'b0;
    writes_rd = 1'b0;
    case (instr_i.r_fmt.opcode)
      OPCODE_OP:                 {use_rs1, use_rs2, writes_rd} = 3'b111;
      OPCODE_STORE:              {use_rs1, use_rs2} = 2'b11;
      OPCODE_OPIMM, OPCODE_LOAD: {use_rs1, writes_rd} = 2'b11;
      OPCODE_LUI, OPCODE_AUIPC:  writes_rd = 1'b1;
      default: ;
    endcase
  end

  assign rs1_hit = use_rs1 && (instr_i.r_fmt.rs1 != '0) && (instr_i.r_fmt.rs1 == last_rd_q);
  assign rs2_hit = use_rs2 && (instr_i.r_fmt.rs2 != '0) && (instr_i.r_fmt.rs2 == last_rd_q);

  // Checked only at the start of an instruction, so one stall at most
  assign raw_hazard_o = fresh_q && (rs1_hit || rs2_hit);

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      last_rd_q <= '0;
      fresh_q   <= 1'b1;
    end else if (accept_i) begin
      last_rd_q <= writes_rd ? instr_i.r_fmt.rd : '0;
      fresh_q   <= 1'b1;
    end else if (state_i != S_NOT_VALID) begin
      fresh_q <= 1'b0;  // Bubbles keep the flag
    end
  end

endmodule

//--- load_wait_timer.sv
// Load wait timer
// Counts the wait cycles that follow a load issue
`timescale 1ns/1ps

module load_wait_timer #(
  parameter int LOAD_WAIT_CYCLES = 3  // 1 to 7
) (
  input  logic clk_i,
  input  logic rstn_i,
  input  logic start_i,
  output logic done_o
);

  logic [2:0] cnt_q;  // Wait cycles left, including the current one

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      cnt_q <= '0;
    end else if (start_i) begin
      cnt_q <= 3'(LOAD_WAIT_CYCLES);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 3'd1;
    end
  end

  assign done_o = (cnt_q == 3'd1);

  // Only one load is in flight
  a_no_restart: assert property (@(posedge clk_i) disable iff (!rstn_i)
    start_i |-> (cnt_q == '0));

endmodule

//--- dec_sequencer.sv
// Decode sequencer
// Steps stores and loads through their phases, inserts the RAW stall
// and drives the ready level back to the IFU
`timescale 1ns/1ps

module dec_sequencer
  import rv_dec_pkg::*;
#(
  parameter int LOAD_WAIT_CYCLES = 3
) (
  input  logic       clk_i,
  input  logic       rstn_i,
  input  instr_u     instr_i,
  input  logic       instr_valid_i,
  input  logic       raw_hazard_i,
  input  logic       load_done_i,
  output seq_state_e state_o,
  output logic       load_start_o,
  output logic       accept_o,
  output logic       ready_o
);

  seq_state_e prev_q;

  //////////////////////////////////////////////////
  // Current state
  //////////////////////////////////////////////////
  always_comb begin
    state_o = S_READY;
    if (!instr_valid_i) begin
      state_o = S_NOT_VALID;
    end else begin
      case (instr_i.r_fmt.opcode)
        OPCODE_STORE: begin
          if (prev_q == S_ST_ADDR)  state_o = S_ST_ISSUE;
          else if (raw_hazard_i)    state_o = S_STALL;
          else                      state_o = S_ST_ADDR;
        end
        OPCODE_LOAD: begin
          if (prev_q == S_LD_ADDR) begin
            state_o = S_LD_ISSUE;
          end else if (prev_q == S_LD_ISSUE || prev_q == S_LD_WAIT) begin
            state_o = S_LD_WAIT;
          end else if (raw_hazard_i) begin
            state_o = S_STALL;
          end else begin
            state_o = S_LD_ADDR;
          end
        end
        // ALU ops, and illegal opcodes which never see a hazard
        default: state_o = raw_hazard_i ? S_STALL : S_READY;
      endcase
    end
  end

  always_comb begin
    case (state_o)
      S_READY, S_ST_ISSUE: ready_o = 1'b1;
      S_LD_WAIT:           ready_o = load_done_i;  // Last wait cycle only
      default:             ready_o = 1'b0;
    endcase
  end

  assign accept_o     = instr_valid_i && ready_o;
  assign load_start_o = (state_o == S_LD_ISSUE);

  //////////////////////////////////////////////////
  // Previous state
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      prev_q <= S_READY;
    end else if (state_o == S_LD_WAIT && load_done_i) begin
      prev_q <= S_READY;  // Load finished, next load starts over
    end else begin
      prev_q <= state_o;
    end
  end

  a_state_onehot: assert property (@(posedge clk_i) disable iff (!rstn_i)
    $onehot(state_o));

  // Timer and sequencer agree on the length of the load wait
  a_load_wait_len: assert property (@(posedge clk_i) disable iff (!rstn_i)
    (state_o == S_LD_WAIT && load_done_i) |-> $past(state_o, LOAD_WAIT_CYCLES) == S_LD_ISSUE);

endmodule

//--- ctrl_regs.sv
// Control decode and output registers
// Decodes the control of the current sequencer state and registers it
// for the ALU, the register file and the LSU
`timescale 1ns/1ps

module ctrl_regs
  import rv_dec_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rstn_i,
  input  instr_u                    instr_i,
  input  logic [DATA_WIDTH-1:0]     instr_addr_i,
  input  logic                      instr_valid_i,
  input  seq_state_e                state_i,
  input  logic [DATA_WIDTH-1:0]     imm_ext_i,
  output imm_sel_e                  imm_sel_o,
  output logic [DATA_WIDTH-1:0]     instr_addr_o,
  output logic                      use_pc_o,
  output logic                      illegal_instr_o,
  output logic [ALU_OP_WIDTH-1:0]   alu_sel_o,
  output logic                      alu_op_a_o,
  output logic                      alu_op_b_o,
  output logic [REG_ADDR_WIDTH-1:0] alu_dest_addr_o,
  output logic                      alu_wb_o,
  output logic [REG_ADDR_WIDTH-1:0] rf_addr_a_o,
  output logic [REG_ADDR_WIDTH-1:0] rf_addr_b_o,
  output logic                      is_imm_o,
  output logic [DATA_WIDTH-1:0]     imm_ext_o,
  output logic                      lsu_ctrl_valid_o,
  output logic [LSU_CTRL_WIDTH-1:0] lsu_ctrl_o,
  output logic [REG_ADDR_WIDTH-1:0] lsu_regdest_o
);

  logic                      use_pc_d;
  logic                      illegal_d;
  logic [ALU_OP_WIDTH-1:0]   alu_sel_d;
  logic                      alu_op_a_d;
  logic                      alu_op_b_d;
  logic [REG_ADDR_WIDTH-1:0] dest_d;
  logic                      alu_wb_d;
  logic [REG_ADDR_WIDTH-1:0] rf_a_d;
  logic [REG_ADDR_WIDTH-1:0] rf_b_d;
  logic                      lsu_valid_d;
  logic [LSU_CTRL_WIDTH-1:0] lsu_ctrl_d;
  logic [REG_ADDR_WIDTH-1:0] regdest_d;
  logic [2:0]                f3;
  logic                      is_shift;

  assign f3       = instr_i.r_fmt.funct3;
  assign is_shift = (f3 == FUNCT3_SHIFT_L) || (f3 == FUNCT3_SHIFT_R);

  //////////////////////////////////////////////////
  // Per-state decode
  //////////////////////////////////////////////////
  always_comb begin
    use_pc_d    = 1'b0;
    illegal_d   = 1'b0;
    alu_sel_d   = ALU_OP_ADD;
    alu_op_a_d  = 1'b0;
    alu_op_b_d  = 1'b0;
    dest_d      = '0;
    alu_wb_d    = 1'b0;
    rf_a_d      = '0;
    rf_b_d      = '0;
    lsu_valid_d = 1'b0;
    lsu_ctrl_d  = '0;
    regdest_d   = '0;
    imm_sel_o   = IMM_NONE;
    case (state_i)
      S_READY: begin
        case (instr_i.r_fmt.opcode)
          OPCODE_OP: begin
            alu_sel_d = {instr_i.r_fmt.funct7[5], f3};  // Bit 30 picks SUB and SRA
            {alu_op_a_d, alu_op_b_d, alu_wb_d} = 3'b111;
            dest_d = instr_i.r_fmt.rd;
            rf_a_d = instr_i.r_fmt.rs1;
            rf_b_d = instr_i.r_fmt.rs2;
          end
          OPCODE_OPIMM: begin
            alu_sel_d  = is_shift ? {instr_i.r_fmt.funct7[5], f3} : {1'b0, f3};
            imm_sel_o  = is_shift ? IMM_SHAMT : IMM_I;
            alu_op_a_d = 1'b1;
            alu_wb_d   = 1'b1;
            dest_d     = instr_i.i_fmt.rd;
            rf_a_d     = instr_i.i_fmt.rs1;
          end
          OPCODE_LUI, OPCODE_AUIPC: begin
            use_pc_d   = (instr_i.u_fmt.opcode == OPCODE_AUIPC);  // PC replaces x0
            imm_sel_o  = IMM_U;
            alu_op_a_d = 1'b1;
            alu_wb_d   = 1'b1;
            dest_d     = instr_i.u_fmt.rd;
          end
          default: illegal_d = 1'b1;  // Consumed with all enables low
        endcase
      end
      S_ST_ADDR, S_LD_ADDR: begin
        alu_op_a_d = 1'b1;
        rf_a_d     = instr_i.r_fmt.rs1;
        rf_b_d     = (state_i == S_ST_ADDR) ? instr_i.s_fmt.rs2 : '0;
        imm_sel_o  = (state_i == S_ST_ADDR) ? IMM_S : IMM_I;
      end
      S_ST_ISSUE: begin
        lsu_valid_d = 1'b1;
        lsu_ctrl_d  = {1'b1, f3};
        rf_a_d      = instr_i.s_fmt.rs1;
        rf_b_d      = instr_i.s_fmt.rs2;  // Store data
      end
      S_LD_ISSUE: begin
        lsu_valid_d = 1'b1;
        lsu_ctrl_d  = {1'b0, f3};
        rf_a_d      = instr_i.i_fmt.rs1;
        regdest_d   = instr_i.i_fmt.rd;
      end
      default: ;  // Stall, load wait and bubble
    endcase
  end

  //////////////////////////////////////////////////
  // Output bank
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      instr_addr_o     <= '0;
      use_pc_o         <= 1'b0;
      illegal_instr_o  <= 1'b0;
      alu_sel_o        <= '0;
      alu_op_a_o       <= 1'b0;
      alu_op_b_o       <= 1'b0;
      alu_dest_addr_o  <= '0;
      alu_wb_o         <= 1'b0;
      rf_addr_a_o      <= '0;
      rf_addr_b_o      <= '0;
      is_imm_o         <= 1'b0;
      imm_ext_o        <= '0;
      lsu_ctrl_valid_o <= 1'b0;
      lsu_ctrl_o       <= '0;
      lsu_regdest_o    <= '0;
    end else if (instr_valid_i) begin
      instr_addr_o     <= instr_addr_i;
      use_pc_o         <= use_pc_d;
      illegal_instr_o  <= illegal_d;
      alu_sel_o        <= alu_sel_d;
      alu_op_a_o       <= alu_op_a_d;
      alu_op_b_o       <= alu_op_b_d;
      alu_dest_addr_o  <= dest_d;
      alu_wb_o         <= alu_wb_d;
      rf_addr_a_o      <= rf_a_d;
      rf_addr_b_o      <= rf_b_d;
      is_imm_o         <= ~alu_op_b_d;
      imm_ext_o        <= imm_ext_i;
      lsu_ctrl_valid_o <= lsu_valid_d;
      lsu_ctrl_o       <= lsu_ctrl_d;
      lsu_regdest_o    <= regdest_d;
    end else begin
      use_pc_o <= 1'b0;  // Everything else holds through a bubble
    end
  end

  a_lsu_or_wb: assert property (@(posedge clk_i) disable iff (!rstn_i)
    !(lsu_ctrl_valid_o && alu_wb_o));

endmodule

//--- rv_decoder.sv
// RV32I decode stage top level
// Connects the sequencer, hazard check, load timer, immediate
// generator and the registered control bank
`timescale 1ns/1ps

module rv_decoder
  import rv_dec_pkg::*;
#(
  parameter int LOAD_WAIT_CYCLES = 3
) (
  input  logic                      clk_i,
  input  logic                      rstn_i,
  input  logic [DATA_WIDTH-1:0]     instr_i,
  input  logic [DATA_WIDTH-1:0]     instr_addr_i,
  input  logic                      instr_valid_i,
  output logic                      ready_o,
  output logic [DATA_WIDTH-1:0]     instr_addr_o,
  output logic                      use_pc_o,
  output logic                      illegal_instr_o,
  output logic [ALU_OP_WIDTH-1:0]   alu_sel_o,
  output logic                      alu_op_a_o,
  output logic                      alu_op_b_o,
  output logic [REG_ADDR_WIDTH-1:0] alu_dest_addr_o,
  output logic                      alu_wb_o,
  output logic [REG_ADDR_WIDTH-1:0] rf_addr_a_o,
  output logic [REG_ADDR_WIDTH-1:0] rf_addr_b_o,
  output logic                      is_imm_o,
  output logic [DATA_WIDTH-1:0]     imm_ext_o,
  output logic                      lsu_ctrl_valid_o,
  output logic [LSU_CTRL_WIDTH-1:0] lsu_ctrl_o,
  output logic [REG_ADDR_WIDTH-1:0] lsu_regdest_o
);

  seq_state_e            state;
  logic                  load_start;
  logic                  load_done;
  logic                  raw_hazard;
  logic                  accept;
  imm_sel_e              imm_sel;
  logic [DATA_WIDTH-1:0] imm_ext;

  dec_sequencer #(.LOAD_WAIT_CYCLES(LOAD_WAIT_CYCLES)) u_seq (
    .clk_i, .rstn_i, .instr_i, .instr_valid_i,
    .raw_hazard_i(raw_hazard), .load_done_i(load_done), .state_o(state),
    .load_start_o(load_start), .accept_o(accept), .ready_o
  );

  load_wait_timer #(.LOAD_WAIT_CYCLES(LOAD_WAIT_CYCLES)) u_timer (
    .clk_i, .rstn_i, .start_i(load_start), .done_o(load_done)
  );

  hazard_check u_hazard (
    .clk_i, .rstn_i, .instr_i, .accept_i(accept), .state_i(state), .raw_hazard_o(raw_hazard)
  );

  imm_gen u_imm (.instr_i, .imm_sel_i(imm_sel), .imm_o(imm_ext));

  ctrl_regs u_ctrl (
    .clk_i, .rstn_i, .instr_i, .instr_addr_i, .instr_valid_i, .state_i(state),
    .imm_ext_i(imm_ext), .imm_sel_o(imm_sel), .instr_addr_o, .use_pc_o, .illegal_instr_o,
    .alu_sel_o, .alu_op_a_o, .alu_op_b_o, .alu_dest_addr_o, .alu_wb_o, .rf_addr_a_o,
    .rf_addr_b_o, .is_imm_o, .imm_ext_o, .lsu_ctrl_valid_o, .lsu_ctrl_o, .lsu_regdest_o
  );

endmodule

//--- tb_rv_decoder.sv
// Testbench for the RV32I decode stage
// Random instruction stream from a fixed seed, checked cycle by cycle
// against a reference model of the stage timing and decode
`timescale 1ns/1ps

module tb_rv_decoder
  import rv_dec_pkg::*;
();

  localparam int LOAD_WAIT_CYCLES = 3;
  localparam int NUM_INSTR        = 1500;
  localparam int MAX_CYCLES       = NUM_INSTR * (LOAD_WAIT_CYCLES + 4) + 100;

  logic        clk_i = 1'b0;
  logic        rstn_i;
  logic [31:0] instr_i;
  logic [31:0] instr_addr_i;
  logic        instr_valid_i;
  logic        ready_o;
  logic [31:0] instr_addr_o;
  logic        use_pc_o;
  logic        illegal_instr_o;
  logic [3:0]  alu_sel_o;
  logic        alu_op_a_o;
  logic        alu_op_b_o;
  logic [4:0]  alu_dest_addr_o;
  logic        alu_wb_o;
  logic [4:0]  rf_addr_a_o;
  logic [4:0]  rf_addr_b_o;
  logic        is_imm_o;
  logic [31:0] imm_ext_o;
  logic        lsu_ctrl_valid_o;
  logic [3:0]  lsu_ctrl_o;
  logic [4:0]  lsu_regdest_o;

  // Expected registered outputs
  typedef struct packed {
    logic [31:0] addr;
    logic        use_pc;
    logic        illegal;
    logic [3:0]  sel;
    logic        op_a;
    logic        op_b;
    logic [4:0]  dest;
    logic        wb;
    logic [4:0]  rf_a;
    logic [4:0]  rf_b;
    logic        is_imm;
    logic [31:0] imm;
    logic        lsu_v;
    logic [3:0]  lsu_ctrl;
    logic [4:0]  regdest;
  } pred_t;

  pred_t       pred;
  logic [31:0] lcg_state;
  logic [31:0] next_addr;
  logic [4:0]  last_rd;    // Last accepted destination
  logic        hz;         // Current word starts with a stall
  logic        need_word;
  int          step;       // Valid cycles spent on the current word
  int          n_done;
  int          n_errs;
  int          n_checks;
  int          cycles;
  logic [31:0] rnd;

  rv_decoder #(.LOAD_WAIT_CYCLES(LOAD_WAIT_CYCLES)) dut (.*);

  initial begin
    forever #4 clk_i = ~clk_i;
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    a_match: assert (got === exp)
      else begin
        n_errs++;
        $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
      end
  endtask

  task automatic check_regs();
    check_val("instr_addr_o", instr_addr_o, pred.addr);
    check_val("use_pc_o", 32'(use_pc_o), 32'(pred.use_pc));
    check_val("illegal_instr_o", 32'(illegal_instr_o), 32'(pred.illegal));
    check_val("alu_sel_o", 32'(alu_sel_o), 32'(pred.sel));
    check_val("alu_op_a_o", 32'(alu_op_a_o), 32'(pred.op_a));
    check_val("alu_op_b_o", 32'(alu_op_b_o), 32'(pred.op_b));
    check_val("alu_dest_addr_o", 32'(alu_dest_addr_o), 32'(pred.dest));
    check_val("alu_wb_o", 32'(alu_wb_o), 32'(pred.wb));
    check_val("rf_addr_a_o", 32'(rf_addr_a_o), 32'(pred.rf_a));
    check_val("rf_addr_b_o", 32'(rf_addr_b_o), 32'(pred.rf_b));
    check_val("is_imm_o", 32'(is_imm_o), 32'(pred.is_imm));
    check_val("imm_ext_o", imm_ext_o, pred.imm);
    check_val("lsu_ctrl_valid_o", 32'(lsu_ctrl_valid_o), 32'(pred.lsu_v));
    check_val("lsu_ctrl_o", 32'(lsu_ctrl_o), 32'(pred.lsu_ctrl));
    check_val("lsu_regdest_o", 32'(lsu_regdest_o), 32'(pred.regdest));
  endtask

  // Weighted toward legal classes, registers from x0 to x3
  task automatic draw_word();
    logic [31:0] r;
    logic [31:0] w;
    r = next_rand();
    w = next_rand();
    w[11:7]  = {3'b0, r[27:26]};
    w[19:15] = {3'b0, r[25:24]};
    w[24:20] = {3'b0, r[23:22]};
    case (r[31:28])
      4'd0, 4'd1, 4'd2, 4'd3:   w[6:0] = OPCODE_OP;
      4'd4, 4'd5, 4'd6, 4'd7:   w[6:0] = OPCODE_OPIMM;
      4'd8:                     w[6:0] = OPCODE_LUI;
      4'd9:                     w[6:0] = OPCODE_AUIPC;
      4'd10, 4'd11:             w[6:0] = OPCODE_STORE;
      4'd12, 4'd13, 4'd14:      w[6:0] = OPCODE_LOAD;
      default:                  w[6:0] = r[21] ? 7'b1100011 : 7'b1110011;  // Branch, SYSTEM
    endcase
    instr_i      = w;
    instr_addr_i = next_addr;
    next_addr    = next_addr + 32'd4;
    step         = 0;
  endtask

  function automatic logic src_hit(input logic [31:0] w);
    logic hit1;
    logic hit2;
    hit1 = (w[19:15] != 5'd0) && (w[19:15] == last_rd);
    hit2 = (w[24:20] != 5'd0) && (w[24:20] == last_rd);
    case (w[6:0])
      OPCODE_OP, OPCODE_STORE:   return hit1 || hit2;
      OPCODE_OPIMM, OPCODE_LOAD: return hit1;
      default:                   return 1'b0;
    endcase
  endfunction

  //////////////////////////////////////////////////
  // Reference model, one call per clock cycle
  //////////////////////////////////////////////////
  task automatic model_cycle();
    logic [6:0] opc;
    logic [2:0] f3;
    logic       shift;
    logic       rdy;
    int         p;
    opc   = instr_i[6:0];
    f3    = instr_i[14:12];
    shift = (f3 == 3'b001) || (f3 == 3'b101);
    rdy   = 1'b0;
    if (!instr_valid_i) begin
      pred.use_pc = 1'b0;  // Bubble holds the rest
    end else begin
      if (step == 0) hz = src_hit(instr_i);
      p           = step - int'(hz);
      pred        = '0;
      pred.is_imm = 1'b1;
      pred.addr   = instr_addr_i;
      if (p < 0) begin
        // RAW stall, nothing enabled
      end else if (opc == OPCODE_STORE) begin
        pred.rf_a = instr_i[19:15];
        pred.rf_b = instr_i[24:20];
        if (p == 0) begin
          pred.op_a = 1'b1;
          pred.imm  = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
        end else begin
          rdy           = 1'b1;
          pred.lsu_v    = 1'b1;
          pred.lsu_ctrl = {1'b1, f3};
        end
      end else if (opc == OPCODE_LOAD) begin
        if (p == 0) begin
          pred.op_a = 1'b1;
          pred.rf_a = instr_i[19:15];
          pred.imm  = {{20{instr_i[31]}}, instr_i[31:20]};
        end else if (p == 1) begin
          pred.lsu_v    = 1'b1;
          pred.lsu_ctrl = {1'b0, f3};
          pred.rf_a     = instr_i[19:15];
          pred.regdest  = instr_i[11:7];
        end else begin
          rdy = (p == LOAD_WAIT_CYCLES + 1);  // Last wait cycle
        end
      end else begin
        rdy = 1'b1;
        case (opc)
          OPCODE_OP: begin
            pred.sel    = {instr_i[30], f3};
            pred.op_a   = 1'b1;
            pred.op_b   = 1'b1;
            pred.is_imm = 1'b0;
            pred.wb     = 1'b1;
            pred.dest   = instr_i[11:7];
            pred.rf_a   = instr_i[19:15];
            pred.rf_b   = instr_i[24:20];
          end
          OPCODE_OPIMM: begin
            pred.sel  = {shift & instr_i[30], f3};
            pred.imm  = shift ? {27'b0, instr_i[24:20]} : {{20{instr_i[31]}}, instr_i[31:20]};
            pred.op_a = 1'b1;
            pred.wb   = 1'b1;
            pred.dest = instr_i[11:7];
            pred.rf_a = instr_i[19:15];
          end
          OPCODE_LUI, OPCODE_AUIPC: begin
            pred.use_pc = (opc == OPCODE_AUIPC);
            pred.imm    = {instr_i[31:12], 12'b0};
            pred.op_a   = 1'b1;
            pred.wb     = 1'b1;
            pred.dest   = instr_i[11:7];
          end
          default: pred.illegal = 1'b1;
        endcase
      end
    end
    check_val("ready_o", 32'(ready_o), 32'(rdy));
    if (instr_valid_i && rdy) begin
      last_rd   = (opc inside {OPCODE_OP, OPCODE_OPIMM, OPCODE_LUI, OPCODE_AUIPC, OPCODE_LOAD})
                  ? instr_i[11:7] : 5'd0;
      need_word = 1'b1;
      n_done++;
    end else if (instr_valid_i) begin
      step++;
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus and end of run
  //////////////////////////////////////////////////
  initial begin
    rstn_i        = 1'b0;
    instr_i       = '0;
    instr_addr_i  = '0;
    instr_valid_i = 1'b0;
    lcg_state     = 32'hc13f_ecae;
    pred          = '0;
    last_rd       = '0;
    hz            = 1'b0;
    step          = 0;
    n_done        = 0;
    n_errs        = 0;
    n_checks      = 0;
    repeat (4) @(negedge clk_i);
    rstn_i    = 1'b1;
    next_addr = next_rand() & 32'hffff_fffc;
    need_word = 1'b1;
    while (n_done < NUM_INSTR) begin
      check_regs();
      if (need_word) begin
        draw_word();
        need_word = 1'b0;
      end
      rnd           = next_rand();
      instr_valid_i = !(step == 0 && rnd[31:29] == 3'd0);  // About one bubble in eight
      #1;
      model_cycle();
      @(negedge clk_i);
    end
    check_regs();
    $display("Errors: %0d mismatches in %0d checks", n_errs, n_checks);
    if (n_errs == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial cycles = 0;

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Errors: %0d mismatches in %0d checks", n_errs, n_checks);
      $display("Done: errors found");
      $finish;
    end
  end

endmodule

//--- flist.f
rv_dec_pkg.sv
imm_gen.sv
hazard_check.sv
load_wait_timer.sv
dec_sequencer.sv
ctrl_regs.sv
rv_decoder.sv
tb_rv_decoder.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the decode stage testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --assert --top-module tb_rv_decoder -f flist.f -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -q "Done: no errors" &&
echo "PASS" || { echo "FAIL"; exit 1; }
